/* verilog.f */
logic/photon_pkg.sv
logic/history_pkg.sv
logic/pulse_counter.sv
logic/history_writer.sv
logic/history_arbiter.sv
logic/uart_reporter.sv
logic/photon_counter_top.sv
tb/photon_counter_assertions.sv
tb/photon_counter_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the photon counter testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f \
    --top-module photon_counter_tb -o photon_counter_sim

./obj_dir/photon_counter_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb/photon_counter_tb.sv */
`timescale 1ns/1ps

module photon_counter_tb;
    import photon_pkg::*;
    import history_pkg::*;

    localparam int CLK_HALF      = 4;               // 8 ns period.
    localparam int N_ROWS        = 7;
    localparam int BURST_ROWS    = HIST_DEPTH + 2;  // Enough to overrun the backlog.
    localparam int BURST_PHOTONS = 2;
    localparam int BURST_GAP     = 4;

    ////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////
    // Photons per window, idle cycles before sync, expected 16-bit entry.
    int          row_photons [0:N_ROWS-1] = '{5, 0, 300, 70000, 17, 256, 1};
    int          row_gap     [0:N_ROWS-1] = '{200, 300, 150, 100, 60, 90, 40};
    logic [15:0] row_entry   [0:N_ROWS-1] = '{16'h0005, 16'h0000, 16'h012c, 16'hffff,
                                              16'h0011, 16'h0100, 16'h0001};

    logic               clk_133MHz_210 = 1'b0;
    logic               rst_n;
    logic               photon_pulse;
    logic               sync_50Hz;
    logic               count_valid;
    logic [COUNT_W-1:0] window_count;
    logic [COUNT_W-1:0] total_count;
    logic               uart_txd;
    logic               led;

    logic [31:0]        lcg_state = 32'hfa1c0c4c;
    logic [COUNT_W-1:0] exp_total = '0;  // Sum of all windows so far.
    logic [31:0]        exp_count [$];
    logic [7:0]         exp_uart  [$];   // Bytes in send order.
    int                 errors       = 0;
    int                 checks       = 0;
    int                 windows_seen = 0;
    int                 cycle_count  = 0;
    int                 cycle_limit  = 0;

    photon_counter_top UUT (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50Hz      (sync_50Hz),
        .count_valid    (count_valid),
        .window_count   (window_count),
        .total_count    (total_count),
        .uart_txd       (uart_txd),
        .led            (led)
    );

    always #CLK_HALF clk_133MHz_210 = ~clk_133MHz_210;

    ////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Windows, sync pulses and both frames of every entry, plus margin.
    function automatic int limit_for_tests();
        int total;
        int k;
        total = 1000;
        for (k = 0; k < N_ROWS; k++) begin
            total += 4 * row_photons[k] + row_gap[k] + 16;  // Worst case jitter.
        end
        total += BURST_ROWS * (4 * BURST_PHOTONS + BURST_GAP + 16) + 64;
        total += N_ROWS * 2 * FRAME_BITS * BAUD_DIV + 2 * BAUD_DIV;
        return total;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // One cycle high, one to three low.
    task automatic send_photons(input int count);
        int i;
        int low;
        for (i = 0; i < count; i++) begin
            photon_pulse <= 1'b1;
            @(posedge clk_133MHz_210);
            photon_pulse <= 1'b0;
            low = 1 + int'((next_rand() >> 16) % 32'd3);
            repeat (low) @(posedge clk_133MHz_210);
        end
    endtask

    // Photons, idle gap, then the sync edge that closes the window.
    task automatic apply_window(input int photons, input int gap);
        int target;
        target = windows_seen + 1;
        exp_count.push_back(32'(photons));
        send_photons(photons);
        repeat (gap) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b1;
        repeat (2) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b0;
        @(posedge clk_133MHz_210);
        while (windows_seen < target) @(posedge clk_133MHz_210);
    endtask

    ////////////////////////////////////////
    // Monitors.
    ////////////////////////////////////////
    always @(posedge clk_133MHz_210) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // Window results sampled mid-cycle.
    always @(negedge clk_133MHz_210) begin : window_monitor
        logic [31:0] expected;
        if (rst_n && count_valid) begin
            if (exp_count.size() == 0) begin
                errors++;
                $display("count_valid rose with no window pending at %0d ns", $time);
            end else begin
                expected  = exp_count.pop_front();
                exp_total = exp_total + expected;
                check_value(window_count, expected, "window_count");
                check_value(total_count, exp_total, "total_count");
            end
            windows_seen++;
        end
    end

    // Serial decoder sampling each bit in its middle.
    initial begin : uart_decoder
        logic [7:0] rx_byte;
        int         b;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk_133MHz_210);
            if (uart_txd == 1'b0) begin
                repeat (BAUD_DIV / 2) @(negedge clk_133MHz_210);
                check_value(32'(uart_txd), 32'd0, "uart start bit");
                for (b = 0; b < 8; b++) begin  // LSB first.
                    repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                    rx_byte[b] = uart_txd;
                end
                for (b = 0; b < FRAME_BITS - 9; b++) begin
                    repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                    check_value(32'(uart_txd), 32'd1, "uart stop bit");
                end
                if (exp_uart.size() == 0) begin
                    errors++;
                    $display("Unexpected UART byte 0x%02h at %0d ns", rx_byte, $time);
                end else begin
                    check_value(32'(rx_byte), 32'(exp_uart.pop_front()), "uart byte");
                end
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////
    initial begin : main_sequence
        int k;
        int e0;
        int w;
        rst_n        <= 1'b0;
        photon_pulse <= 1'b0;
        sync_50Hz    <= 1'b0;
        cycle_limit   = limit_for_tests();
        repeat (3) @(posedge clk_133MHz_210);
        rst_n <= 1'b1;
        @(negedge clk_133MHz_210);
        e0 = errors;
        check_value(32'(led), 32'd0, "led after reset");
        check_value(32'(count_valid), 32'd0, "count_valid after reset");
        check_value(32'(uart_txd), 32'd1, "uart_txd after reset");
        finish_test("reset", e0);
        @(posedge clk_133MHz_210);

        for (k = 0; k < N_ROWS; k++) begin
            e0 = errors;
            exp_uart.push_back(row_entry[k][15:8]);  // High byte first.
            exp_uart.push_back(row_entry[k][7:0]);
            apply_window(row_photons[k], row_gap[k]);
            finish_test($sformatf("window %0d", k), e0);
        end

        // Let the backlog drain and the line settle.
        e0 = errors;
        while (exp_uart.size() != 0) @(posedge clk_133MHz_210);
        repeat (BAUD_DIV) @(posedge clk_133MHz_210);
        check_value(32'(led), 32'd0, "led before burst");
        finish_test("uart drain", e0);

        // Short windows pile up faster than one frame.
        e0 = errors;
        for (k = 0; k < BURST_ROWS; k++) begin
            apply_window(BURST_PHOTONS, BURST_GAP);
        end
        w = 0;
        while (!led && w < 64) begin
            @(posedge clk_133MHz_210);
            w++;
        end
        check_value(32'(led), 32'd1, "led after overflow");
        finish_test("overflow", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb/photon_counter_assertions.sv */
`timescale 1ns/1ps

module photon_counter_assertions (
    input  logic                                clk_133MHz_210,
    input  logic                                rst_n,
    input  logic                                req,            // Client request.
    input  logic [history_pkg::HIST_ADDR_W-1:0] addr,
    input  logic                                done,           // Matching done pulse.
    input  logic                                other_done,     // Done of the other client.
    input  logic                                backlog_empty,
    input  logic                                uart_txd
);

    ////////////////////////////////////////
    // Memory handshake.
    ////////////////////////////////////////
    done_single_cycle: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        done |=> !done)
        else $error("Done pulse held for more than one cycle.");

    // Address must not move before done.
    req_held_until_done: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        req && !done |=> req && $stable(addr))
        else $error("Request or address changed before done.");

    done_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(done && other_done))
        else $error("Read and write done in the same cycle.");

    ////////////////////////////////////////
    // Serial line.
    ////////////////////////////////////////
    line_idle_when_empty: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        backlog_empty |-> uart_txd)
        else $error("UART line low with an empty backlog.");

endmodule

// Write side checked inside the arbiter.
bind history_arbiter photon_counter_assertions wr_port_checks (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .req            (wr_req),
    .addr           (wr_addr),
    .done           (wr_done),
    .other_done     (rd_done),
    .backlog_empty  (1'b0),
    .uart_txd       (1'b1)
);

// Read side and line checked inside the reporter.
bind uart_reporter photon_counter_assertions rd_port_checks (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .req            (rd_req),
    .addr           (rd_addr),
    .done           (rd_done),
    .other_done     (1'b0),
    .backlog_empty  (backlog == '0),
    .uart_txd       (uart_txd)
);

/* logic/photon_counter_top.sv */
`timescale 1ns/1ps

module photon_counter_top (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    input  logic                           photon_pulse,  // External detector pulse.
    input  logic                           sync_50Hz,     // Window marker.
    output logic                           count_valid,
    output logic [photon_pkg::COUNT_W-1:0] window_count,
    output logic [photon_pkg::COUNT_W-1:0] total_count,
    output logic                           uart_txd,
    output logic                           led            // History overflow.
);
    import history_pkg::*;

    // Write client to arbiter.
    logic                   wr_req;
    logic [HIST_ADDR_W-1:0] wr_addr;
    logic [ENTRY_W-1:0]     wr_data;
    logic                   wr_done;
    // Read client to arbiter.
    logic                   rd_req;
    logic [HIST_ADDR_W-1:0] rd_addr;
    logic                   rd_done;
    logic [ENTRY_W-1:0]     rd_data;

    logic entry_written;  // Writer to reporter notice.

    ////////////////////////////////////////
    // Counting and history.
    ////////////////////////////////////////
    pulse_counter ic_pulse_counter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50Hz      (sync_50Hz),
        .count_valid    (count_valid),
        .window_count   (window_count),
        .total_count    (total_count)
    );

    history_writer ic_history_writer (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .count_valid    (count_valid),
        .window_count   (window_count),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_done        (wr_done),
        .entry_written  (entry_written)
    );

    // Shared memory port.
    history_arbiter ic_history_arbiter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_done        (wr_done),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done),
        .rd_data        (rd_data)
    );

    ////////////////////////////////////////
    // Serial reporting.
    ////////////////////////////////////////
    uart_reporter ic_uart_reporter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .entry_written  (entry_written),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done),
        .rd_data        (rd_data),
        .uart_txd       (uart_txd),
        .led            (led)
    );

endmodule

/* logic/uart_reporter.sv */
`timescale 1ns/1ps

module uart_reporter (
    input  logic                               clk_133MHz_210,
    input  logic                               rst_n,
    input  logic                               entry_written,  // New entry in memory.
    output logic                               rd_req,
    output logic [history_pkg::HIST_ADDR_W-1:0] rd_addr,
    input  logic                               rd_done,
    input  logic [history_pkg::ENTRY_W-1:0]     rd_data,
    output logic                               uart_txd,       // Idle high.
    output logic                               led             // Sticky overflow.
);
    import photon_pkg::*;
    import history_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_SEND} state_t;

    state_t                state;
    logic [HIST_ADDR_W-1:0] rd_ptr;    // Oldest unsent entry.
    logic [BACKLOG_W-1:0]  backlog;   // Waiting entries including the in-flight one.
    logic                  taken;     // In-flight entry already out of the backlog.
    logic [ENTRY_W-1:0]    entry;
    logic                  byte_sel;  // Low while the high byte goes out.
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [FRAME_BITS-1:0] frame;
    logic                  bit_end;
    logic                  send_end;
    logic                  consume;
    logic                  overflow;

    // Start bit at index 0 and two stop bits on top.
    assign frame    = {2'b11, byte_sel ? entry[7:0] : entry[ENTRY_W-1 -: 8], 1'b0};
    assign bit_end  = (state == S_SEND) && (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
    assign send_end = bit_end && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1)) && byte_sel;
    assign consume  = send_end && !taken;
    assign overflow = entry_written && (backlog == BACKLOG_W'(HIST_DEPTH)) && !consume;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rd_ptr   <= '0;
            backlog  <= '0;
            taken    <= 1'b0;
            byte_sel <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rd_req   <= 1'b0;
            rd_addr  <= '0;
            uart_txd <= 1'b1;
            led      <= 1'b0;
        end else begin
            ////////////////////////////////////////
            // Backlog and overflow.
            ////////////////////////////////////////
            if (entry_written && !consume && !overflow) begin
                backlog <= backlog + 1'b1;
            end else if (consume && !entry_written) begin
                backlog <= backlog - 1'b1;
            end
            if (consume || overflow) begin
                rd_ptr <= rd_ptr + 1'b1;  // Overflow skips the overwritten slot.
            end
            if (overflow) begin
                led <= 1'b1;
            end
            if (send_end) begin
                taken <= 1'b0;
            end else if (overflow && state != S_IDLE) begin
                taken <= 1'b1;  // Its slot now holds the newest entry.
            end
            ////////////////////////////////////////
            // Read and transmit FSM.
            ////////////////////////////////////////
            case (state)
                S_IDLE: begin
                    uart_txd <= 1'b1;
                    // Wait out a notice because rd_ptr may move with it.
                    if (backlog != '0 && !entry_written) begin
                        rd_req  <= 1'b1;
                        rd_addr <= rd_ptr;
                        state   <= S_READ;
                    end
                end
                S_READ: begin
                    if (rd_done) begin
                        rd_req   <= 1'b0;
                        byte_sel <= 1'b0;  // High byte first.
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    uart_txd <= frame[bit_idx];  // LSB first after start.
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1)) begin
                            bit_idx  <= '0;
                            byte_sel <= 1'b1;
                            if (byte_sel) begin
                                state <= S_IDLE;  // Both frames out.
                            end
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Entry being shifted out.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == S_READ && rd_done) begin
            entry <= rd_data;
        end
    end

endmodule

/* logic/history_arbiter.sv */
`timescale 1ns/1ps

module history_arbiter (
    input  logic                               clk_133MHz_210,
    input  logic                               rst_n,
    // Write client.
    input  logic                               wr_req,
    input  logic [history_pkg::HIST_ADDR_W-1:0] wr_addr,
    input  logic [history_pkg::ENTRY_W-1:0]     wr_data,
    output logic                               wr_done,
    // Read client.
    input  logic                               rd_req,
    input  logic [history_pkg::HIST_ADDR_W-1:0] rd_addr,
    output logic                               rd_done,
    output logic [history_pkg::ENTRY_W-1:0]     rd_data   // Valid with rd_done.
);
    import history_pkg::*;

    logic [ENTRY_W-1:0] mem [0:HIST_DEPTH-1];  // Single-port history RAM.

    logic last_rd;   // Read side was served last.
    logic busy;
    logic wr_grant;
    logic rd_grant;

    // No grant while a done is out since the client still holds its request.
    assign busy = wr_done | rd_done;

    // Round robin between two clients.
    assign wr_grant = ~busy & wr_req & (~rd_req | last_rd);
    assign rd_grant = ~busy & rd_req & ~wr_grant;

    ////////////////////////////////////////
    // Grant bookkeeping and done pulses.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wr_done <= 1'b0;
            rd_done <= 1'b0;
            last_rd <= 1'b0;
        end else begin
            wr_done <= wr_grant;  // One cycle after grant.
            rd_done <= rd_grant;
            if (wr_grant) begin
                last_rd <= 1'b0;
            end else if (rd_grant) begin
                last_rd <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // RAM access port.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210) begin
        if (wr_grant) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_grant) begin
            rd_data <= mem[rd_addr];  // Lands together with rd_done.
        end
    end

endmodule

/* logic/history_writer.sv */
`timescale 1ns/1ps

module history_writer (
    input  logic                               clk_133MHz_210,
    input  logic                               rst_n,
    input  logic                               count_valid,
    input  logic [photon_pkg::COUNT_W-1:0]     window_count,
    output logic                               wr_req,
    output logic [history_pkg::HIST_ADDR_W-1:0] wr_addr,     // Circular pointer.
    output logic [history_pkg::ENTRY_W-1:0]     wr_data,
    input  logic                               wr_done,
    output logic                               entry_written  // One cycle per write.
);
    import photon_pkg::*;
    import history_pkg::*;

    logic               over_range;
    logic [ENTRY_W-1:0] entry_sat;

    // Clamp anything above the entry range to all ones.
    assign over_range = |window_count[COUNT_W-1:ENTRY_W];
    assign entry_sat  = over_range ? {ENTRY_W{1'b1}} : window_count[ENTRY_W-1:0];

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wr_req        <= 1'b0;
            wr_addr       <= '0;
            entry_written <= 1'b0;
        end else begin
            entry_written <= 1'b0;
            if (wr_req) begin
                if (wr_done) begin
                    wr_req        <= 1'b0;  // Low the cycle after done.
                    wr_addr       <= wr_addr + 1'b1;  // Wraps at HIST_DEPTH.
                    entry_written <= 1'b1;
                end
            end else if (count_valid) begin
                wr_req <= 1'b1;
            end
            // A strobe during a pending write is lost.
        end
    end

    // Held stable for the whole request.
    always_ff @(posedge clk_133MHz_210) begin
        if (count_valid && !wr_req) begin
            wr_data <= entry_sat;
        end
    end

endmodule

/* logic/pulse_counter.sv */
`timescale 1ns/1ps

module pulse_counter (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    input  logic                           photon_pulse,  // Raw detector pin.
    input  logic                           sync_50Hz,     // Raw window marker.
    output logic                           count_valid,
    output logic [photon_pkg::COUNT_W-1:0] window_count,
    output logic [photon_pkg::COUNT_W-1:0] total_count
);
    import photon_pkg::*;

    // Top bit is the delayed copy for edge detection.
    logic [SYNC_STAGES:0] photon_sync;
    logic [SYNC_STAGES:0] sync_sync;
    logic                 photon_rise;
    logic                 sync_rise;
    logic [COUNT_W-1:0]   running;    // Photons in the open window.

    assign photon_rise = photon_sync[SYNC_STAGES-1] & ~photon_sync[SYNC_STAGES];
    assign sync_rise   = sync_sync[SYNC_STAGES-1] & ~sync_sync[SYNC_STAGES];

    ////////////////////////////////////////
    // Input synchronizers.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_sync <= '0;
            sync_sync   <= '0;
        end else begin
            photon_sync <= {photon_sync[SYNC_STAGES-1:0], photon_pulse};
            sync_sync   <= {sync_sync[SYNC_STAGES-1:0], sync_50Hz};
        end
    end

    ////////////////////////////////////////
    // Window counting.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            count_valid  <= 1'b0;
            running      <= '0;
            window_count <= '0;
            total_count  <= '0;
        end else begin
            count_valid <= 1'b0;  // Strobe.
            if (sync_rise) begin
                // Photon on the sync edge opens the new window.
                running      <= COUNT_W'(photon_rise);
                window_count <= running;
                total_count  <= total_count + running;  // Only reset clears it.
                count_valid  <= 1'b1;
            end else begin
                running <= running + COUNT_W'(photon_rise);
            end
        end
    end

endmodule

/* logic/history_pkg.sv */
package history_pkg;

    ////////////////////////////////////////
    // History memory.
    ////////////////////////////////////////

    // One stored entry, also the saturation limit.
    localparam int ENTRY_W = 16;

    localparam int HIST_DEPTH  = 16;                  // Entries kept.
    localparam int HIST_ADDR_W = $clog2(HIST_DEPTH);  // Circular address.

    // Backlog must hold HIST_DEPTH itself.
    localparam int BACKLOG_W = HIST_ADDR_W + 1;

endpackage

/* logic/photon_pkg.sv */
package photon_pkg;

    ////////////////////////////////////////
    // Photon counting.
    ////////////////////////////////////////

    // Window count and running total.
    localparam int COUNT_W = 32;

    localparam int SYNC_STAGES = 2;  // Flops per input pin.

    ////////////////////////////////////////
    // Serial link.
    ////////////////////////////////////////

    // 133.333 MHz over 115200 baud.
    localparam int BAUD_DIV = 1157;

    // Start, eight data, two stop.
    localparam int FRAME_BITS = 11;

    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);  // Clocks within one bit.
    localparam int BIT_IDX_W  = $clog2(FRAME_BITS); // Bit position in frame.

endpackage
